// File: design/cpuPkg.sv
package cpuPkg;

    localparam int wordW = 32;
    localparam logic [wordW-1:0] resetVector = 32'h0000_1000;
    localparam int aluLatency = 4; // execute strobe to done

    typedef logic [3:0] regIdx_t;

    localparam regIdx_t regZero = 4'd0;
    localparam regIdx_t regPc = 4'd15; // reads as next address

    typedef enum logic [3:0] {
        opOr     = 4'h0,
        opAnd    = 4'h1,
        opXor    = 4'h2,
        opSra    = 4'h3,
        opAdd    = 4'h4,
        opMul    = 4'h5,
        opEq     = 4'h6,
        opLt     = 4'h7,
        opOrNot  = 4'h8,
        opAndNot = 4'h9,
        opPack   = 4'ha, // a << 12 with low 12 bits of b
        opSrl    = 4'hb,
        opSub    = 4'hc,
        opShl    = 4'hd,
        opTest   = 4'he, // bit b of a
        opGe     = 4'hf
    } aluOp_e;

    typedef enum logic [1:0] {
        fmtXYI   = 2'b00,
        fmtXIY   = 2'b01,
        fmtIXY   = 2'b10,
        fmtImm20 = 2'b11
    } fmtKind_e;

    typedef enum logic [1:0] {
        derefNone     = 2'b00, // z = rhs
        derefStoreZ   = 2'b01, // mem[rhs] = z
        derefStoreRhs = 2'b10, // mem[z] = rhs
        derefLoad     = 2'b11  // z = mem[rhs]
    } derefMode_e;

endpackage

// File: design/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
    import cpuPkg::*;

    regIdx_t          idxZ;
    regIdx_t          idxX;
    regIdx_t          idxY;
    logic [wordW-1:0] imm;
    aluOp_e           op;
    fmtKind_e         kind;
    logic             storing;
    logic             loading;
    logic             derefRhs;
    logic             branching;

    modport src (
        output idxZ, idxX, idxY, imm, op, kind,
        output storing, loading, derefRhs, branching
    );

    modport dst (
        input idxZ, idxX, idxY, imm, op, kind,
        input storing, loading, derefRhs, branching
    );

endinterface

// File: design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic [cpuPkg::wordW-1:0] instr_i,
    decodeIf.src                     dec
);
    import cpuPkg::*;

    derefMode_e  mode;
    logic [19:0] immField;

    // kind, mode, z, x, then y/op/imm12 or imm20
    assign dec.kind = fmtKind_e'(instr_i[31:30]);
    assign mode     = derefMode_e'(instr_i[29:28]);
    assign dec.idxZ = instr_i[27:24];
    assign dec.idxX = instr_i[23:20];
    assign immField = instr_i[19:0];

    always_comb begin
        if (dec.kind == fmtImm20) begin
            dec.idxY = regZero;
            dec.op   = opOr;
            dec.imm  = {{(wordW-20){immField[19]}}, immField};
        end else begin
            dec.idxY = immField[19:16];
            dec.op   = aluOp_e'(immField[15:12]);
            dec.imm  = {{(wordW-12){immField[11]}}, immField[11:0]};
        end
    end

    assign dec.storing  = mode inside {derefStoreZ, derefStoreRhs};
    assign dec.loading  = mode == derefLoad;
    assign dec.derefRhs = mode inside {derefStoreZ, derefLoad}; // low mode bit

    // a store names z as data or address, never as a target
    assign dec.branching = (dec.idxZ == regPc) && !dec.storing;

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                     clk,
    decodeIf.dst                     dec,
    input  logic                     we_i,
    input  logic [cpuPkg::wordW-1:0] wdata_i,
    input  logic [cpuPkg::wordW-1:0] nextPc_i,
    output logic [cpuPkg::wordW-1:0] valZ_o,
    output logic [cpuPkg::wordW-1:0] valX_o,
    output logic [cpuPkg::wordW-1:0] valY_o
);
    import cpuPkg::*;

    logic [wordW-1:0] regs [1:14] = '{default: '0};
    logic             writable;

    function automatic logic [wordW-1:0] readReg(input regIdx_t idx);
        if (idx == regZero) begin
            return '0;
        end else if (idx == regPc) begin
            return nextPc_i; // pc lives in the sequencer
        end
        return regs[idx];
    endfunction

    always_comb begin
        valZ_o = readReg(dec.idxZ);
        valX_o = readReg(dec.idxX);
        valY_o = readReg(dec.idxY);
    end

    assign writable = (dec.idxZ != regZero) && (dec.idxZ != regPc);

    always_ff @(posedge clk) begin
        if (we_i && writable) begin
            regs[dec.idxZ] <= wdata_i;
        end
    end

    // z reads back the write, unchanged if dropped
    writeReadBack: assert property (@(posedge clk)
        we_i |=> (dec.idxZ != $past(dec.idxZ))
            || (valZ_o == ($past(writable) ? $past(wdata_i) : $past(valZ_o))));

endmodule

// File: design/operandRouter.sv
`timescale 1ns/1ps

module operandRouter (
    decodeIf.dst                     dec,
    input  logic [cpuPkg::wordW-1:0] valX_i,
    input  logic [cpuPkg::wordW-1:0] valY_i,
    output logic [cpuPkg::wordW-1:0] opA_o,
    output logic [cpuPkg::wordW-1:0] opB_o,
    output logic [cpuPkg::wordW-1:0] opC_o
);
    import cpuPkg::*;

    always_comb begin
        case (dec.kind)
            fmtXYI: begin
                opA_o = valX_i;
                opB_o = valY_i;
                opC_o = dec.imm;
            end
            fmtXIY: begin
                opA_o = valX_i;
                opB_o = dec.imm;
                opC_o = valY_i;
            end
            fmtIXY: begin
                opA_o = dec.imm;
                opB_o = valX_i;
                opC_o = valY_i;
            end
            default: begin // imm20, plain x + imm
                opA_o = '0;
                opB_o = valX_i;
                opC_o = dec.imm;
            end
        endcase
    end

endmodule

// File: design/aluPipe.sv
`timescale 1ns/1ps

module aluPipe (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     execStb_i,
    input  cpuPkg::aluOp_e           op_i,
    input  logic [cpuPkg::wordW-1:0] opA_i,
    input  logic [cpuPkg::wordW-1:0] opB_i,
    input  logic [cpuPkg::wordW-1:0] opC_i,
    output logic [cpuPkg::wordW-1:0] result_o,
    output logic                     done_o
);
    import cpuPkg::*;

    aluOp_e                opReg;
    logic [wordW-1:0]      aReg;
    logic [wordW-1:0]      bReg;
    logic [wordW-1:0]      cReg;
    logic [wordW-1:0]      opRes;
    logic [aluLatency-1:0] stbPipe; // one bit per cycle since strobe

    function automatic logic [wordW-1:0] applyOp(input aluOp_e op,
                                                 input logic [wordW-1:0] a,
                                                 input logic [wordW-1:0] b);
        logic signed [wordW-1:0] sa;
        logic signed [wordW-1:0] sb;
        logic [wordW-1:0]        y;
        sa = a;
        sb = b;
        case (op)
            opOr:     y = a | b;
            opAnd:    y = a & b;
            opXor:    y = a ^ b;
            opSra:    y = sa >>> b;
            opAdd:    y = a + b;
            opMul:    y = a * b;
            opEq:     y = {wordW{a == b}};
            opLt:     y = {wordW{sa < sb}};
            opOrNot:  y = a | ~b;
            opAndNot: y = a & ~b;
            opPack:   y = {a[wordW-13:0], b[11:0]};
            opSrl:    y = a >> b;
            opSub:    y = a - b;
            opShl:    y = a << b;
            opTest:   y = {wordW{(b < wordW) && a[b[4:0]]}};
            opGe:     y = {wordW{sa >= sb}};
            default:  y = '0;
        endcase
        return y;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            stbPipe <= '0;
        end else begin
            stbPipe <= {stbPipe[aluLatency-2:0], execStb_i};
        end
    end

    always_ff @(posedge clk) begin
        if (execStb_i) begin // stage 1, operands
            opReg <= op_i;
            aReg  <= opA_i;
            bReg  <= opB_i;
            cReg  <= opC_i;
        end
        if (stbPipe[0]) begin // stage 2
            opRes <= applyOp(opReg, aReg, bReg);
        end
        if (stbPipe[1]) begin // stage 3, held till next strobe
            result_o <= opRes + cReg;
        end
    end

    assign done_o = stbPipe[aluLatency-1];

    stbToDone: assert property (@(posedge clk) disable iff (reset)
        execStb_i |-> ##aluLatency done_o);

    doneFromStb: assert property (@(posedge clk) disable iff (reset)
        done_o |-> $past(execStb_i, aluLatency));

endmodule

// File: design/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic                     clk,
    input  logic                     reset,
    output logic [cpuPkg::wordW-1:0] adr_o,
    input  logic [cpuPkg::wordW-1:0] dat_i,
    output logic [cpuPkg::wordW-1:0] dat_o,
    output logic                     wen_o,
    output logic                     stb_o,
    output logic                     cyc_o,
    input  logic                     ack_i,
    input  logic                     err_i,
    input  logic                     retry_i,
    output logic                     halt_o
);
    import cpuPkg::*;

    typedef enum logic [2:0] {
        sFetch,
        sLatch,
        sExec,
        sWaitExec,
        sAddr,
        sData,
        sWriteback
    } seqState_e;

    seqState_e        state;
    logic [wordW-1:0] instrReg;
    logic [wordW-1:0] nextPc;
    logic [wordW-1:0] rhsReg;
    logic [wordW-1:0] loadData;
    logic [wordW-1:0] valZ;
    logic [wordW-1:0] valX;
    logic [wordW-1:0] valY;
    logic [wordW-1:0] opA;
    logic [wordW-1:0] opB;
    logic [wordW-1:0] opC;
    logic [wordW-1:0] aluResult;
    logic [wordW-1:0] wdata;
    logic [wordW-1:0] dataAdr;
    logic             execStb;
    logic             aluDone;
    logic             regWe;
    logic             memAccess;

    decodeIf dec ();

    instrDecoder u_decoder (
        .instr_i (instrReg),
        .dec     (dec)
    );

    regFile u_regs (
        .clk      (clk),
        .dec      (dec),
        .we_i     (regWe),
        .wdata_i  (wdata),
        .nextPc_i (nextPc),
        .valZ_o   (valZ),
        .valX_o   (valX),
        .valY_o   (valY)
    );

    operandRouter u_router (
        .dec    (dec),
        .valX_i (valX),
        .valY_i (valY),
        .opA_o  (opA),
        .opB_o  (opB),
        .opC_o  (opC)
    );

    aluPipe u_alu (
        .clk       (clk),
        .reset     (reset),
        .execStb_i (execStb),
        .op_i      (dec.op),
        .opA_i     (opA),
        .opB_i     (opB),
        .opC_i     (opC),
        .result_o  (aluResult),
        .done_o    (aluDone)
    );

    assign halt_o    = err_i | retry_i;
    assign memAccess = dec.loading | dec.storing;
    assign execStb   = (state == sExec) && !halt_o; // stall here on halt
    assign regWe     = (state == sWriteback) && !dec.storing;
    assign wdata     = dec.derefRhs ? loadData : rhsReg;
    assign dataAdr   = dec.derefRhs ? rhsReg : valZ;
    assign dat_o     = dec.derefRhs ? valZ : rhsReg;
    assign stb_o     = (state == sFetch) || (state == sData);
    assign cyc_o     = stb_o;
    assign wen_o     = (state == sData) && dec.storing;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sFetch;
            adr_o <= resetVector;
        end else begin
            case (state)
                sFetch: if (ack_i) state <= sLatch;
                sLatch: state <= sExec; // decode and register reads settle
                sExec: if (!halt_o) state <= sWaitExec;
                sWaitExec: if (aluDone) state <= sAddr;
                sAddr: begin
                    adr_o <= dataAdr;
                    state <= memAccess ? sData : sWriteback;
                end
                sData: if (ack_i) state <= sWriteback;
                default: begin // writeback
                    adr_o <= dec.branching ? wdata : nextPc;
                    state <= sFetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == sFetch && ack_i) begin
            instrReg <= dat_i;
            nextPc   <= adr_o + 1'b1;
        end
        if (state == sWaitExec && aluDone) begin
            rhsReg <= aluResult;
        end
        if (state == sData && ack_i) begin
            loadData <= dat_i;
        end
    end

    busHold: assert property (@(posedge clk) disable iff (reset)
        stb_o && !ack_i |=> stb_o && $stable(adr_o) && $stable(wen_o));

endmodule

// File: bench/busModel.sv
`timescale 1ns/1ps

module busModel #(
    parameter int errLen = 6 // cycles of err after the armed fetch
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    input  logic        wen_i,
    input  logic        stb_i,
    input  logic        cyc_i,
    output logic        ack_o,
    output logic        err_o,
    output logic        retry_o,
    input  logic        errArm_i,
    input  logic [31:0] errAdr_i
);
    logic [31:0] mem [0:8191];
    logic [31:0] lfsr = 32'h80a891eb;
    logic        pending = 1'b0;
    logic        errFired = 1'b0;
    int          waitLeft = 0;
    int          errLeft = 0;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // 0 to 3 wait states, two bits per access
    task automatic drawWaits(output int n);
        n = 0;
        for (int i = 0; i < 2; i++) begin
            n = (n << 1) | lfsr[0];
            lfsr = lfsrStep(lfsr);
        end
    endtask

    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = {16'(i) ^ 16'hc3a5, ~16'(i)};
        end
        dat_o = '0;
        ack_o = 1'b0;
        err_o = 1'b0;
    end

    assign retry_o = 1'b0;

    always @(negedge clk) begin
        if (errLeft > 0) begin
            err_o <= 1'b1;
            errLeft--;
        end else begin
            err_o <= 1'b0;
        end
        if (reset) begin
            ack_o <= 1'b0;
            pending = 1'b0;
        end else if (ack_o) begin
            ack_o <= 1'b0; // transfer took place at the last rising edge
        end else if (stb_i && cyc_i) begin
            if (!pending) begin
                drawWaits(waitLeft);
                pending = 1'b1;
            end
            if (waitLeft == 0) begin
                ack_o   <= 1'b1;
                dat_o   <= mem[adr_i[12:0]];
                pending = 1'b0;
                if (errArm_i && !errFired && !wen_i && adr_i == errAdr_i) begin
                    errFired = 1'b1;
                    errLeft  = errLen; // err rises once the fetch is done
                end
            end else begin
                waitLeft--;
            end
        end
    end

    // write capture
    always @(posedge clk) begin
        if (stb_i && ack_o && wen_i) begin
            mem[adr_i[12:0]] <= dat_i;
        end
    end

endmodule

// File: bench/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int maxAcc = 128;
    localparam int errCycles = 10;
    localparam logic [31:0] branchTarget = 32'h0000_1800;

    logic        clk = 1'b0;
    logic        reset;
    logic        errArm;
    logic [31:0] adr;
    logic [31:0] rdData;
    logic [31:0] wrData;
    logic        wen;
    logic        stb;
    logic        cyc;
    logic        ack;
    logic        err;
    logic        retry;
    logic        halt;
    logic [31:0] prevAdr;
    logic [31:0] prevDat;
    logic        prevWen;
    logic        built = 1'b0;

    logic [31:0] expAdr [maxAcc];
    logic        expWen [maxAcc];
    logic [31:0] expDat [maxAcc];
    logic [31:0] pc;
    int          nAcc = 0;
    int          nInstr = 0;
    int          accIdx = 0;
    int          errCount = 0;

    cpuCore u_dut (
        .clk     (clk),
        .reset   (reset),
        .adr_o   (adr),
        .dat_i   (rdData),
        .dat_o   (wrData),
        .wen_o   (wen),
        .stb_o   (stb),
        .cyc_o   (cyc),
        .ack_i   (ack),
        .err_i   (err),
        .retry_i (retry),
        .halt_o  (halt)
    );

    busModel #(.errLen(errCycles)) u_mem (
        .clk      (clk),
        .reset    (reset),
        .adr_i    (adr),
        .dat_i    (wrData),
        .dat_o    (rdData),
        .wen_i    (wen),
        .stb_i    (stb),
        .cyc_i    (cyc),
        .ack_o    (ack),
        .err_o    (err),
        .retry_o  (retry),
        .errArm_i (errArm),
        .errAdr_i (resetVector + 32'd10)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] refOp(input aluOp_e op, input logic [31:0] a,
                                          input logic [31:0] b);
        logic [31:0]        y;
        logic signed [31:0] sa;
        case (op)
            opOr:     y = a | b;
            opAnd:    y = a & b;
            opXor:    y = a ^ b;
            opSra: begin
                sa = $signed(a) >>> b[4:0];
                y  = (b > 31) ? {32{a[31]}} : sa;
            end
            opAdd:    y = a + b;
            opMul:    y = a * b;
            opEq:     y = (a == b) ? '1 : '0;
            opLt:     y = ($signed(a) < $signed(b)) ? '1 : '0;
            opOrNot:  y = a | ~b;
            opAndNot: y = a & ~b;
            opPack:   y = (a << 12) | (b & 32'hfff);
            opSrl:    y = (b > 31) ? '0 : a >> b[4:0];
            opSub:    y = a - b;
            opShl:    y = (b > 31) ? '0 : a << b[4:0];
            opTest:   y = (b < 32 && a[b[4:0]]) ? '1 : '0;
            default:  y = ($signed(a) >= $signed(b)) ? '1 : '0; // ge
        endcase
        return y;
    endfunction

    function automatic logic [31:0] encode(input fmtKind_e kind, input derefMode_e mode,
                                           input logic [3:0] z, input logic [19:0] low);
        return {kind, mode, z, 4'd0, low}; // x is always r0
    endfunction

    task automatic addAccess(input logic [31:0] a, input logic w, input logic [31:0] d);
        expAdr[nAcc] = a;
        expWen[nAcc] = w;
        expDat[nAcc] = d;
        nAcc++;
    endtask

    task automatic emit(input logic [31:0] word);
        u_mem.mem[pc[12:0]] = word;
        addAccess(pc, 1'b0, 32'h0);
        pc++;
        nInstr++;
    endtask

    task automatic buildProgram;
        logic [11:0] imm;
        logic [31:0] immExt;
        logic [31:0] rhs;
        aluOp_e      op;
        pc = resetVector;
        for (int k = 0; k < 3; k++) begin
            for (int o = 0; o < 16; o++) begin
                op     = aluOp_e'(o);
                imm    = 12'(o * 'h1d3 + k * 'h2b5 + 'h807);
                immExt = {{20{imm[11]}}, imm};
                case (fmtKind_e'(k))
                    fmtXYI:  rhs = refOp(op, 32'h0, 32'h0) + immExt;
                    fmtXIY:  rhs = refOp(op, 32'h0, immExt);
                    default: rhs = refOp(op, immExt, 32'h0);
                endcase
                emit(encode(fmtKind_e'(k), derefStoreRhs, 4'd0, {4'd0, op, imm}));
                addAccess(32'h0, 1'b1, rhs); // mem[r0] = rhs
            end
        end
        emit(encode(fmtImm20, derefStoreRhs, 4'd0, 20'h81234));
        addAccess(32'h0, 1'b1, 32'hfff8_1234);
        emit(encode(fmtImm20, derefStoreRhs, 4'd0, 20'h07abc));
        addAccess(32'h0, 1'b1, 32'h0000_7abc);
        emit(encode(fmtImm20, derefLoad, 4'd1, 20'h0)); // r1 = mem[0]
        addAccess(32'h0, 1'b0, 32'h0);
        emit(encode(fmtImm20, derefStoreZ, 4'd1, 20'h40));
        addAccess(32'h40, 1'b1, 32'h0000_7abc);
        emit(encode(fmtImm20, derefNone, regZero, 20'h55)); // dropped write
        emit(encode(fmtImm20, derefStoreZ, regZero, 20'h41));
        addAccess(32'h41, 1'b1, 32'h0);
        emit(encode(fmtImm20, derefNone, regPc, branchTarget[19:0]));
        pc = branchTarget;
        emit(encode(fmtImm20, derefStoreRhs, 4'd0, 20'hfffff));
        addAccess(32'h0, 1'b1, 32'hffff_ffff);
    endtask

    task automatic reportValue(input string name, input logic [31:0] expV,
                               input logic [31:0] actV);
        errCount++;
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expV, actV);
    endtask

    task automatic reportFault(input string what);
        errCount++;
        $display("at %0t ns: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (!reset && stb && ack) begin
            accIdx <= accIdx + 1;
        end
        prevAdr <= adr;
        prevDat <= wrData;
        prevWen <= wen;
    end

    firstFetch: assert property (@(posedge clk) $fell(reset) |-> stb && adr == resetVector)
        else reportValue("adr_o", resetVector, $sampled(adr));

    cycWithStb: assert property (@(posedge clk) disable iff (reset) cyc == stb)
        else reportValue("cyc_o", $sampled(stb), $sampled(cyc));

    accessLimit: assert property (@(posedge clk) disable iff (reset)
        stb && ack |-> accIdx < nAcc)
        else reportFault("bus access beyond the end of the program");

    accessAdr: assert property (@(posedge clk) disable iff (reset)
        stb && ack && accIdx < nAcc |-> adr == expAdr[accIdx])
        else reportValue("adr_o", $sampled(expAdr[accIdx]), $sampled(adr));

    accessWen: assert property (@(posedge clk) disable iff (reset)
        stb && ack && accIdx < nAcc |-> wen == expWen[accIdx])
        else reportValue("wen_o", $sampled(expWen[accIdx]), $sampled(wen));

    accessDat: assert property (@(posedge clk) disable iff (reset)
        stb && ack && wen && accIdx < nAcc |-> wrData == expDat[accIdx])
        else reportValue("dat_o", $sampled(expDat[accIdx]), $sampled(wrData));

    // wait states
    holdStb: assert property (@(posedge clk) disable iff (reset) stb && !ack |=> stb)
        else reportFault("stb_o dropped before ack_i");

    holdAdr: assert property (@(posedge clk) disable iff (reset)
        stb && !ack |=> adr === prevAdr)
        else reportValue("adr_o", $sampled(prevAdr), $sampled(adr));

    holdDat: assert property (@(posedge clk) disable iff (reset)
        stb && !ack |=> wrData === prevDat)
        else reportValue("dat_o", $sampled(prevDat), $sampled(wrData));

    holdWen: assert property (@(posedge clk) disable iff (reset)
        stb && !ack |=> wen === prevWen)
        else reportValue("wen_o", $sampled(prevWen), $sampled(wen));

    haltOnErr: assert property (@(posedge clk) disable iff (reset) err |-> halt)
        else reportValue("halt_o", 32'h1, $sampled(halt));

    noStartOnHalt: assert property (@(posedge clk) disable iff (reset)
        halt && !stb |=> !stb)
        else reportFault("a bus access started while halt_o was high");

    // per instruction: 9 core cycles, two accesses with up to 3 waits, 2 spare
    initial begin
        wait (built);
        repeat (nInstr * (9 + 2 * 3 + 2) + 5 + errCycles + 20) @(posedge clk);
        $display("timeout: %0d of %0d bus accesses seen", accIdx, nAcc);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        reset  = 1'b1;
        errArm = 1'b0;
        @(negedge clk);
        buildProgram();
        built = 1'b1;
        repeat (4) @(negedge clk);
        reset  = 1'b0;
        errArm = 1'b1;
        wait (accIdx == nAcc);
        @(negedge clk);
        if (!u_mem.errFired) begin
            reportFault("the error response was never raised");
        end
        $display("checks failed: %0d, bus accesses seen: %0d of %0d", errCount, accIdx, nAcc);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: cpuCore.f
design/cpuPkg.sv
design/decodeIf.sv
design/instrDecoder.sv
design/regFile.sv
design/operandRouter.sv
design/aluPipe.sv
design/cpuCore.sv
bench/busModel.sv
bench/cpuTb.sv
